// File: rtl/cplx_decode.sv
module cplx_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_val,
  output logic                  cmd_rdy,
  input  cplx_pkg::cplx_cmd_t   cmd,
  output logic                  op_val,
  input  logic                  op_rdy,
  output cplx_pkg::cplx_oper_t  op
);

  cplx_pkg::cplx_oper_t dec;  // decoded form of the incoming command
  logic                 accept;

  // the single slot can take a new command when empty or when it drains this cycle
  assign cmd_rdy = !op_val || op_rdy;
  assign accept = cmd_val && cmd_rdy;

  always_comb begin
    dec.tag = cmd.tag;
    dec.ar = cmd.ar;
    dec.ac = cmd.ac;
    dec.br = cmd.br;
    dec.bc = cmd.bc;
    case (cmd.opcode)
      cplx_pkg::op_mul: begin
        dec.kind = cplx_pkg::kind_mul;
      end
      cplx_pkg::op_mulc: begin
        // conj(b) flips the sign of the imaginary part only
        dec.kind = cplx_pkg::kind_mul;
        dec.bc = -cmd.bc;
      end
      cplx_pkg::op_sub: begin
        dec.kind = cplx_pkg::kind_add;
        dec.br = -cmd.br;  // a - b becomes a + (-b)
        dec.bc = -cmd.bc;
      end
      default: begin
        // op_add, and anything unexpected falls back to add
        dec.kind = cplx_pkg::kind_add;
      end
    endcase
  end

  // valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      op_val <= 1'b0;
    end else if (accept) begin
      op_val <= 1'b1;
    end else if (op_rdy) begin
      op_val <= 1'b0;  // slot drained with nothing behind it
    end
  end

  // operation payload
  always_ff @(posedge clk) begin
    if (accept) begin
      op <= dec;
    end
  end

endmodule

// File: rtl/cplx_execute.sv
`include "cplx_settings.svh"

module cplx_execute (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  op_val,
  output logic                  op_rdy,
  input  cplx_pkg::cplx_oper_t  op,
  output logic                  res_val,
  input  logic                  res_rdy,
  output cplx_pkg::cplx_res_t   res
);

  // real part is ar*br - ac*bc
  // imaginary part is (ar+ac)(br+bc) - ar*br - ac*bc, which saves one multiply

  cplx_pkg::exec_state_e  state;
  cplx_pkg::exec_state_e  next_state;

  logic [`CPLX_WIDTH-1:0] ar_q;
  logic [`CPLX_WIDTH-1:0] ac_q;
  logic [`CPLX_WIDTH-1:0] br_q;
  logic [`CPLX_WIDTH-1:0] bc_q;
  logic [3:0]             tag_q;

  logic [`CPLX_WIDTH-1:0] arxbr;   // first product, held for both result parts
  logic [`CPLX_WIDTH-1:0] acxbc;
  logic [`CPLX_WIDTH-1:0] cr_q;
  logic [`CPLX_WIDTH-1:0] cc_q;

  logic [`CPLX_WIDTH-1:0] mul_a;
  logic [`CPLX_WIDTH-1:0] mul_b;
  logic [`CPLX_WIDTH-1:0] mul_p;

  logic                   accept;

  assign op_rdy = (state == cplx_pkg::st_idle);
  assign res_val = (state == cplx_pkg::st_done);
  assign accept = op_val && op_rdy;

  always_comb begin
    next_state = state;
    mul_a = '0;
    mul_b = '0;
    case (state)
      cplx_pkg::st_idle: begin
        if (op_val) begin
          // adds finish on acceptance
          next_state = (op.kind == cplx_pkg::kind_mul) ? cplx_pkg::st_mul1
                                                       : cplx_pkg::st_done;
        end
      end
      cplx_pkg::st_mul1: begin
        next_state = cplx_pkg::st_mul2;
        mul_a = ar_q;
        mul_b = br_q;
      end
      cplx_pkg::st_mul2: begin
        next_state = cplx_pkg::st_mul3;
        mul_a = ac_q;
        mul_b = bc_q;
      end
      cplx_pkg::st_mul3: begin
        next_state = cplx_pkg::st_done;
        mul_a = ar_q + ac_q;  // both sums wrap before the multiply
        mul_b = br_q + bc_q;
      end
      cplx_pkg::st_done: begin
        if (res_rdy) next_state = cplx_pkg::st_idle;  // hold result under back-pressure
      end
      default: begin
        next_state = cplx_pkg::st_idle;
      end
    endcase
  end

  fixed_mult u_mult (
    .a (mul_a),
    .b (mul_b),
    .p (mul_p)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cplx_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  // operands, partial products and result carry no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      ar_q <= op.ar;
      ac_q <= op.ac;
      br_q <= op.br;
      bc_q <= op.bc;
      tag_q <= op.tag;
      cr_q <= op.ar + op.br;  // only kept for the add path
      cc_q <= op.ac + op.bc;
    end
    if (state == cplx_pkg::st_mul1) arxbr <= mul_p;
    if (state == cplx_pkg::st_mul2) acxbc <= mul_p;
    if (state == cplx_pkg::st_mul3) begin
      // the third product goes straight into the imaginary part
      cr_q <= arxbr - acxbc;
      cc_q <= mul_p - arxbr - acxbc;
    end
  end

  assign res.tag = tag_q;
  assign res.cr = cr_q;
  assign res.cc = cc_q;

endmodule

// File: rtl/cplx_pkg.sv
`include "cplx_settings.svh"

package cplx_pkg;

  // opcodes as seen on the command port
  typedef enum logic [1:0] {
    op_mul  = 2'd0,  // a * b
    op_mulc = 2'd1,  // a * conj(b)
    op_add  = 2'd2,
    op_sub  = 2'd3
  } cplx_op_e;

  // decode folds the four opcodes into these two datapath kinds
  typedef enum logic [0:0] {
    kind_mul = 1'b0,
    kind_add = 1'b1
  } exec_kind_e;

  typedef enum logic [2:0] {
    st_idle = 3'd0,
    st_mul1 = 3'd1,  // ar * br
    st_mul2 = 3'd2,  // ac * bc
    st_mul3 = 3'd3,  // (ar + ac) * (br + bc)
    st_done = 3'd4
  } exec_state_e;

  typedef struct packed {
    cplx_op_e               opcode;
    logic [3:0]             tag;
    logic [`CPLX_WIDTH-1:0] ar;
    logic [`CPLX_WIDTH-1:0] ac;
    logic [`CPLX_WIDTH-1:0] br;
    logic [`CPLX_WIDTH-1:0] bc;
  } cplx_cmd_t;

  // operands here already carry any negation needed by mulc and sub
  typedef struct packed {
    exec_kind_e             kind;
    logic [3:0]             tag;
    logic [`CPLX_WIDTH-1:0] ar;
    logic [`CPLX_WIDTH-1:0] ac;
    logic [`CPLX_WIDTH-1:0] br;
    logic [`CPLX_WIDTH-1:0] bc;
  } cplx_oper_t;

  typedef struct packed {
    logic [3:0]             tag;
    logic [`CPLX_WIDTH-1:0] cr;
    logic [`CPLX_WIDTH-1:0] cc;
  } cplx_res_t;

endpackage

// File: rtl/cplx_result.sv
`include "cplx_settings.svh"

module cplx_result (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 res_val,
  output logic                 res_rdy,
  input  cplx_pkg::cplx_res_t  res,
  output logic                 out_val,
  input  logic                 out_rdy,
  output cplx_pkg::cplx_res_t  out
);

  localparam int DEPTH = `CPLX_RESULT_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  cplx_pkg::cplx_res_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // occupied entries
  logic             wr_en;
  logic             rd_en;

  assign res_rdy = (count != CNT_W'(DEPTH));
  assign out_val = (count != '0);
  assign out = mem[rd_ptr];

  assign wr_en = res_val && res_rdy;
  assign rd_en = out_val && out_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // a simultaneous write and read leaves the count alone
      case ({wr_en, rd_en})
        2'b10: count <= count + CNT_W'(1);
        2'b01: count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= res;
    end
  end

endmodule

// File: rtl/cplx_settings.svh
`ifndef CPLX_SETTINGS_SVH
`define CPLX_SETTINGS_SVH

// width of one real or imaginary component
`define CPLX_WIDTH 32

// fraction bits of the fixed-point format
`define CPLX_FRAC 16

`define CPLX_RESULT_DEPTH 2  // entries in the output buffer

`endif

// File: rtl/cplx_unit.sv
module cplx_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_val,
  output logic                 cmd_rdy,
  input  cplx_pkg::cplx_cmd_t  cmd,
  output logic                 out_val,
  input  logic                 out_rdy,
  output cplx_pkg::cplx_res_t  out
);

  // decode to execute
  cplx_pkg::cplx_oper_t op;
  logic                 op_val;
  logic                 op_rdy;

  // execute to result buffer
  cplx_pkg::cplx_res_t  res;
  logic                 res_val;
  logic                 res_rdy;

  cplx_decode u_decode (
    .clk     (clk),
    .reset   (reset),
    .cmd_val (cmd_val),
    .cmd_rdy (cmd_rdy),
    .cmd     (cmd),
    .op_val  (op_val),
    .op_rdy  (op_rdy),
    .op      (op)
  );

  cplx_execute u_execute (
    .clk     (clk),
    .reset   (reset),
    .op_val  (op_val),
    .op_rdy  (op_rdy),
    .op      (op),
    .res_val (res_val),
    .res_rdy (res_rdy),
    .res     (res)
  );

  cplx_result u_result (
    .clk     (clk),
    .reset   (reset),
    .res_val (res_val),
    .res_rdy (res_rdy),
    .res     (res),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out     (out)
  );

endmodule

// File: rtl/fixed_mult.sv
`include "cplx_settings.svh"

module fixed_mult (
  input  logic [`CPLX_WIDTH-1:0] a,
  input  logic [`CPLX_WIDTH-1:0] b,
  output logic [`CPLX_WIDTH-1:0] p
);

  logic signed [`CPLX_WIDTH-1:0]   a_s;
  logic signed [`CPLX_WIDTH-1:0]   b_s;
  logic signed [2*`CPLX_WIDTH-1:0] full;     // exact signed product
  logic signed [2*`CPLX_WIDTH-1:0] shifted;

  assign a_s = a;
  assign b_s = b;
  assign full = a_s * b_s;

  // drop the extra fraction bits, keeping the sign
  assign shifted = full >>> `CPLX_FRAC;

  // upper bits are discarded so the result wraps like every other sum
  assign p = shifted[`CPLX_WIDTH-1:0];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary -f sources.f --top-module tb_cplx_unit --Mdir obj_dir -o tb_cplx_unit
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/tb_cplx_unit)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

// File: sources.f
+incdir+rtl
rtl/cplx_pkg.sv
rtl/fixed_mult.sv
rtl/cplx_decode.sv
rtl/cplx_execute.sv
rtl/cplx_result.sv
rtl/cplx_unit.sv
test/tb_cplx_unit.sv

// File: test/cplx_testdata.txt
# opcode tag ar ac br bc exp_cr exp_cc, all in hex, operands in Q16.16
# opcode 0 is multiply, 1 multiply by conjugate, 2 add, 3 subtract
0 1 00020000 00030000 00040000 00050000 fff90000 00160000
0 2 00018000 ffff8000 fffe0000 00004000 fffd2000 00016000
0 3 00000003 fffffffd 00008000 00008000 00000003 00000001
0 4 7fff0000 00000000 00020000 00000000 fffe0000 00000000
1 5 00020000 00030000 00040000 00050000 00170000 00020000
1 6 00008000 00004000 0000c000 ffff8000 00004000 00007000
1 7 00010000 00000000 00000000 80000000 00000000 80000000
3 8 00050000 ffff0000 00020000 00030000 00030000 fffc0000
3 9 00000000 00000000 80000000 00000001 80000000 ffffffff
3 a 7fffffff 80000000 ffffffff 00000001 80000000 7fffffff
2 b 00018000 00024000 00008000 fffd0000 00020000 ffff4000
2 c 7fff0000 80000000 00010000 ffffffff 80000000 7fffffff
2 d ffffffff 12345678 00000001 11111111 00000000 23456789
0 e ffff0000 ffff0000 ffff0000 ffff0000 00000000 00020000
0 f 7fff0000 00010000 00010000 00000000 7fff0000 00010000
1 0 ffffffff 00000001 00008000 00008000 00000000 00000002
2 1 00010000 00020000 00030000 00040000 00040000 00060000
3 2 00014000 00008000 00014000 0000c000 00000000 ffffc000
0 3 00000000 00010000 00000000 00010000 ffff0000 00000000
1 4 00030000 fffe0000 00010000 00010000 00010000 fffb0000
2 5 fffd8000 00070000 00010000 fff88000 fffe8000 ffff8000
0 6 00008000 00008000 00008000 ffff8000 00008000 00000000
3 7 00000000 00010000 00010000 80000000 ffff0000 80010000

// File: test/tb_cplx_unit.sv
`include "cplx_settings.svh"

module tb_cplx_unit;

  localparam int MAX_CMDS = 64;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DELAY = 10;  // inputs change this long after the rising edge
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_CMD = 40;
  localparam int NUM_STREAMS = 3;

  logic                clk;
  logic                reset;
  logic                cmd_val;
  logic                cmd_rdy;
  cplx_pkg::cplx_cmd_t cmd;
  logic                out_val;
  logic                out_rdy;
  cplx_pkg::cplx_res_t out;

  // one entry per line of the data file
  logic [1:0]             op_mem [MAX_CMDS];
  logic [3:0]             tag_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] ar_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] ac_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] br_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] bc_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] exp_cr_mem [MAX_CMDS];
  logic [`CPLX_WIDTH-1:0] exp_cc_mem [MAX_CMDS];

  int num_cmds;
  int err_count;     // errors seen in the test that is running
  int tests_passed;
  int tests_failed;
  bit load_failed;

  cplx_unit uut (
    .clk     (clk),
    .reset   (reset),
    .cmd_val (cmd_val),
    .cmd_rdy (cmd_rdy),
    .cmd     (cmd),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out     (out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_testdata();
    int fd;
    int n;
    string line;
    logic [7:0] f_op;
    logic [7:0] f_tag;
    logic [`CPLX_WIDTH-1:0] f_ar;
    logic [`CPLX_WIDTH-1:0] f_ac;
    logic [`CPLX_WIDTH-1:0] f_br;
    logic [`CPLX_WIDTH-1:0] f_bc;
    logic [`CPLX_WIDTH-1:0] f_cr;
    logic [`CPLX_WIDTH-1:0] f_cc;
    num_cmds = 0;
    fd = $fopen("test/cplx_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open test/cplx_testdata.txt");
      load_failed = 1'b1;
      return;
    end
    while (!$feof(fd) && num_cmds < MAX_CMDS) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 2) continue;  // blank line or end of file
      if (line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                  f_op, f_tag, f_ar, f_ac, f_br, f_bc, f_cr, f_cc);
      if (n != 8) begin
        $display("malformed line in test data: %s", line);
        load_failed = 1'b1;
        continue;
      end
      op_mem[num_cmds] = f_op[1:0];
      tag_mem[num_cmds] = f_tag[3:0];
      ar_mem[num_cmds] = f_ar;
      ac_mem[num_cmds] = f_ac;
      br_mem[num_cmds] = f_br;
      bc_mem[num_cmds] = f_bc;
      exp_cr_mem[num_cmds] = f_cr;
      exp_cc_mem[num_cmds] = f_cc;
      num_cmds++;
    end
    $fclose(fd);
    if (num_cmds == 0) begin
      $display("test data file holds no commands");
      load_failed = 1'b1;
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == 0) begin
      $display("test %s: passed", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", name, err_count);
      tests_failed++;
    end
  endtask

  task automatic drive_commands(input bit with_gaps);
    int gap;
    for (int i = 0; i < num_cmds; i++) begin
      if (with_gaps && ($urandom % 3 == 0)) begin
        gap = 1 + ($urandom % 3);
        repeat (gap) begin
          @(posedge clk);
          #DRIVE_DELAY;
        end
      end
      cmd_val = 1'b1;
      cmd.opcode = cplx_pkg::cplx_op_e'(op_mem[i]);
      cmd.tag = tag_mem[i];
      cmd.ar = ar_mem[i];
      cmd.ac = ac_mem[i];
      cmd.br = br_mem[i];
      cmd.bc = bc_mem[i];
      @(negedge clk);
      while (!cmd_rdy) begin
        @(negedge clk);  // hold the command until decode takes it
      end
      @(posedge clk);
      #DRIVE_DELAY;
      cmd_val = 1'b0;
    end
  endtask

  task automatic compare_result(input int k);
    if (out.tag !== tag_mem[k]) begin
      $display("ERR t=%0t: tag %h left the unit where tag %h was due", $time, out.tag,
               tag_mem[k]);
      err_count++;
    end
    if (out.cr !== exp_cr_mem[k] || out.cc !== exp_cc_mem[k]) begin
      $display("ERR t=%0t tag %h: got cr %h cc %h, expected cr %h cc %h", $time,
               out.tag, out.cr, out.cc, exp_cr_mem[k], exp_cc_mem[k]);
      err_count++;
    end
  endtask

  task automatic check_results(input bit random_stall);
    int k;
    k = 0;
    while (k < num_cmds) begin
      out_rdy = random_stall ? (($urandom % 4) != 0) : 1'b1;  // ready about 3 cycles in 4
      @(negedge clk);
      if (out_val && out_rdy) begin
        compare_result(k);
        k++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    out_rdy = 1'b1;
  endtask

  // once every result is in, the unit must stay quiet
  task automatic check_drained();
    repeat (8) begin
      @(negedge clk);
      if (out_val) begin
        $display("unexpected extra result with tag %h at time %0t", out.tag, $time);
        err_count++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic run_stream(input string name, input bit with_gaps, input bit random_stall);
    err_count = 0;
    fork
      drive_commands(with_gaps);
      check_results(random_stall);
    join
    check_drained();
    finish_test(name);
  endtask

  task automatic check_idle_after_reset();
    err_count = 0;
    repeat (6) begin
      @(negedge clk);
      if (out_val !== 1'b0) begin
        $display("a result appeared at time %0t before any command was sent", $time);
        err_count++;
      end
      if (cmd_rdy !== 1'b1) begin
        $display("cmd_rdy was not high at time %0t with the unit idle", $time);
        err_count++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    finish_test("reset_idle");
  endtask

  // watchdog sized from the number of commands in the data file
  initial begin
    int limit;
    #1;
    limit = RESET_CYCLES + CYCLES_PER_CMD * num_cmds * NUM_STREAMS + 64;
    #(limit * CLK_PERIOD);
    $display("timeout: results did not arrive within %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    void'($urandom(89));
    reset = 1'b1;
    cmd_val = 1'b0;
    cmd = '0;
    out_rdy = 1'b0;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    load_failed = 1'b0;
    load_testdata();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    out_rdy = 1'b1;
    check_idle_after_reset();
    if (!load_failed) begin
      run_stream("gapped_random_stall", 1'b1, 1'b1);
      run_stream("back_to_back_random_stall", 1'b0, 1'b1);
      run_stream("back_to_back_no_stall", 1'b0, 1'b0);
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && !load_failed) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
